// ==== logic/usb_sie_pkg.sv ====
// register map and line codes for a full-speed only SIE with two downstream ports
package usb_sie_pkg;

	localparam int addr_w = 6;
	localparam int byte_w = 8;

	typedef logic [addr_w-1:0] addr_t; // microcontroller register address
	typedef logic [byte_w-1:0] byte_t;

	// encoded as the {d+, d-} pin levels, full speed idle is J
	typedef enum logic [1:0] {
		se0     = 2'b00,
		k_state = 2'b01,
		j_state = 2'b10,
		se1     = 2'b11
	} line_state_t;

	// status of both ports
	localparam addr_t reg_line_state_a = 6'h00;
	localparam addr_t reg_line_state_b = 6'h01;
	localparam addr_t reg_discon_a     = 6'h02;
	localparam addr_t reg_discon_b     = 6'h03;

	// bit 0 of port_sel_tx drives port a, bit 1 port b
	localparam addr_t reg_port_sel_rx  = 6'h04;
	localparam addr_t reg_port_sel_tx  = 6'h05;

	localparam addr_t reg_tx_data      = 6'h06; // write loads a byte and starts a packet
	localparam addr_t reg_tx_pending   = 6'h07;
	localparam addr_t reg_tx_valid     = 6'h08; // any write ends the packet
	localparam addr_t reg_gen_reset    = 6'h09;

	localparam addr_t reg_rx_data      = 6'h0a; // read clears rx_pending
	localparam addr_t reg_rx_pending   = 6'h0b;
	localparam addr_t reg_rx_active    = 6'h0c;
	localparam addr_t reg_rx_error     = 6'h0d; // sticky for the current packet

endpackage

// ==== logic/usb_sie_regs.sv ====
// register file holds a single transmit byte and overwrites a receive byte that was not read
`timescale 1ns/10ps

module usb_sie_regs (
	input  logic                     usb_clk,
	input  logic                     usb_rst,

	input  logic                     io_re,
	input  logic                     io_we,
	input  usb_sie_pkg::addr_t       io_a,
	input  usb_sie_pkg::byte_t       io_di,
	output usb_sie_pkg::byte_t       io_do,

	input  usb_sie_pkg::line_state_t line_state_a,
	input  usb_sie_pkg::line_state_t line_state_b,
	input  logic                     discon_a,
	input  logic                     discon_b,

	output logic                     port_sel_rx,
	output logic [1:0]               port_sel_tx,

	output usb_sie_pkg::byte_t       tx_data,
	output logic                     tx_valid,
	input  logic                     tx_ready,
	output logic                     gen_reset,

	input  usb_sie_pkg::byte_t       rx_data,
	input  logic                     rx_valid,
	input  logic                     rx_active,
	input  logic                     rx_error
);

	logic               tx_pending;  // byte written but not yet taken by the serializer
	logic               rx_pending;  // byte received but not yet read
	logic               rx_err_flag;
	logic               rx_active_q; // for the start of packet edge
	usb_sie_pkg::byte_t rx_byte;
	usb_sie_pkg::byte_t rd_mux;

	// read data for the address on the bus, registered below
	always_comb begin
		rd_mux = '0;
		case (io_a)
			usb_sie_pkg::reg_line_state_a: rd_mux = {6'd0, line_state_a};
			usb_sie_pkg::reg_line_state_b: rd_mux = {6'd0, line_state_b};
			usb_sie_pkg::reg_discon_a:     rd_mux = {7'd0, discon_a};
			usb_sie_pkg::reg_discon_b:     rd_mux = {7'd0, discon_b};
			usb_sie_pkg::reg_port_sel_rx:  rd_mux = {7'd0, port_sel_rx};
			usb_sie_pkg::reg_port_sel_tx:  rd_mux = {6'd0, port_sel_tx};
			usb_sie_pkg::reg_tx_data:      rd_mux = tx_data;
			usb_sie_pkg::reg_tx_pending:   rd_mux = {7'd0, tx_pending};
			usb_sie_pkg::reg_tx_valid:     rd_mux = {7'd0, tx_valid};
			usb_sie_pkg::reg_gen_reset:    rd_mux = {7'd0, gen_reset};
			usb_sie_pkg::reg_rx_data:      rd_mux = rx_byte;
			usb_sie_pkg::reg_rx_pending:   rd_mux = {7'd0, rx_pending};
			usb_sie_pkg::reg_rx_active:    rd_mux = {7'd0, rx_active};
			usb_sie_pkg::reg_rx_error:     rd_mux = {7'd0, rx_err_flag};
			default:                       rd_mux = '0; // unused addresses read zero
		endcase
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			io_do       <= '0;
			port_sel_rx <= 1'b0;
			port_sel_tx <= 2'b00;
			tx_data     <= '0;
			tx_valid    <= 1'b0;
			tx_pending  <= 1'b0;
			gen_reset   <= 1'b0;
			rx_byte     <= '0;
			rx_pending  <= 1'b0;
			rx_err_flag <= 1'b0;
			rx_active_q <= 1'b0;
		end else begin
			io_do       <= rd_mux;
			rx_active_q <= rx_active;

			if (io_re && io_a == usb_sie_pkg::reg_rx_data)
				rx_pending <= 1'b0;

			// taken byte, a new write in the same cycle wins
			if (tx_ready)
				tx_pending <= 1'b0;

			if (io_we) begin
				case (io_a)
					usb_sie_pkg::reg_port_sel_rx: port_sel_rx <= io_di[0];
					usb_sie_pkg::reg_port_sel_tx: port_sel_tx <= io_di[1:0];
					usb_sie_pkg::reg_tx_data: begin
						tx_data    <= io_di;
						tx_valid   <= 1'b1;
						tx_pending <= 1'b1;
					end
					usb_sie_pkg::reg_tx_valid:    tx_valid <= 1'b0; // EOP after the current byte
					usb_sie_pkg::reg_gen_reset:   gen_reset <= io_di[0];
					default: ;
				endcase
			end

			if (rx_valid) begin
				rx_byte    <= rx_data;
				rx_pending <= 1'b1;
			end

			// error flag lives for one packet
			if (rx_active && !rx_active_q)
				rx_err_flag <= 1'b0;
			if (rx_active && rx_error)
				rx_err_flag <= 1'b1;
		end
	end

endmodule

// ==== logic/usb_tx_serializer.sv ====
// serializer sends SYNC and stuffed NRZI data and EOP but no CRC and needs clks_per_bit of 2 or more
`timescale 1ns/10ps

module usb_tx_serializer #(
	parameter int clks_per_bit = 4
) (
	input  logic               usb_clk,
	input  logic               usb_rst,
	input  usb_sie_pkg::byte_t tx_data,
	input  logic               tx_valid,
	output logic               tx_ready,
	output logic               drive_dp,
	output logic               drive_dm,
	output logic               drive_oe
);

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [7:0] sync_pattern = 8'h80; // KJKJKJKK once NRZI coded

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_sync = 2'd1;
	localparam logic [1:0] st_data = 2'd2;
	localparam logic [1:0] st_eop  = 2'd3;

	logic [1:0]       state;
	logic [cnt_w-1:0] cnt;       // position inside the bit time
	logic [7:0]       sreg;
	logic [3:0]       bits_left;
	logic [2:0]       ones;      // run of ones sent so far
	logic [1:0]       eop_cnt;
	logic             lvl;       // line level, 1 is J

	logic bit_end;
	logic stuff;
	logic need_byte;
	logic eop_start;
	logic bit_out;
	logic next_lvl;

	assign bit_end   = (cnt == cnt_w'(clks_per_bit - 1));
	assign stuff     = (ones == 3'd6);
	assign need_byte = (bits_left == 4'd0);
	assign eop_start = need_byte && !stuff && !tx_valid;
	assign tx_ready  = (state == st_sync || state == st_data) && bit_end &&
		need_byte && !stuff && tx_valid;

	assign bit_out  = need_byte ? tx_data[0] : sreg[0];
	assign next_lvl = (stuff || !bit_out) ? ~lvl : lvl; // a zero toggles the line

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state     <= st_idle;
			cnt       <= '0;
			bits_left <= '0;
			ones      <= '0;
			eop_cnt   <= '0;
			lvl       <= 1'b1;
			drive_dp  <= 1'b1;
			drive_dm  <= 1'b0;
			drive_oe  <= 1'b0;
		end else begin
			cnt <= (state == st_idle || bit_end) ? '0 : cnt + 1'b1;
			case (state)
				st_idle: if (tx_valid) begin
					// first SYNC bit goes out right away
					state     <= st_sync;
					sreg      <= sync_pattern >> 1;
					bits_left <= 4'd7;
					ones      <= '0;
					lvl       <= 1'b0;
					drive_dp  <= 1'b0;
					drive_dm  <= 1'b1;
					drive_oe  <= 1'b1;
				end
				st_sync, st_data: if (bit_end) begin
					if (eop_start) begin
						state    <= st_eop;
						eop_cnt  <= '0;
						drive_dp <= 1'b0;
						drive_dm <= 1'b0;
					end else begin
						lvl      <= next_lvl;
						drive_dp <= next_lvl;
						drive_dm <= ~next_lvl;
						ones     <= (stuff || !bit_out) ? 3'd0 : ones + 3'd1;
					end
					if (!stuff && !need_byte) begin
						sreg      <= sreg >> 1;
						bits_left <= bits_left - 4'd1;
					end
					if (tx_ready) begin
						state     <= st_data;
						sreg      <= tx_data >> 1; // bit 0 is already on the line
						bits_left <= 4'd7;
					end
				end
				st_eop: if (bit_end) begin
					eop_cnt <= eop_cnt + 2'd1;
					if (eop_cnt == 2'd1) begin
						lvl      <= 1'b1; // J after two SE0 bit times
						drive_dp <= 1'b1;
						drive_dm <= 1'b0;
					end else if (eop_cnt == 2'd2) begin
						state    <= st_idle;
						drive_oe <= 1'b0;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// ==== logic/usb_rx_deserializer.sv ====
// deserializer samples at fixed oversampling without clock recovery and drops a partial last byte
`timescale 1ns/10ps

module usb_rx_deserializer #(
	parameter int clks_per_bit = 4
) (
	input  logic                     usb_clk,
	input  logic                     usb_rst,
	input  usb_sie_pkg::line_state_t rx_line,
	output usb_sie_pkg::byte_t       rx_data,
	output logic                     rx_valid,
	output logic                     rx_active,
	output logic                     rx_error
);

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [7:0] sync_levels = 8'b0101_0100; // d+ of KJKJKJKK, oldest in bit 7

	usb_sie_pkg::line_state_t prev_line;
	logic [cnt_w-1:0] cnt;      // phase inside the bit, 0 at a line change
	logic [7:0]       sync_sr;
	logic [7:0]       shift;
	logic [2:0]       bit_cnt;
	logic [2:0]       ones;
	logic             last_lvl; // previous sampled d+ level

	logic       edge_seen;
	logic       sample;
	logic       dp;
	logic       bit_in;
	logic       is_se0;
	logic       is_se1;
	logic [7:0] sync_next;

	assign edge_seen = (rx_line != prev_line);
	assign sample    = !edge_seen && (cnt == cnt_w'(clks_per_bit / 2)); // mid-bit
	assign dp        = rx_line[1];
	assign bit_in    = (dp == last_lvl); // NRZI, no change is a one
	assign is_se0    = (rx_line == usb_sie_pkg::se0);
	assign is_se1    = (rx_line == usb_sie_pkg::se1);
	assign sync_next = {sync_sr[6:0], dp};

	always_ff @(posedge usb_clk)
		prev_line <= rx_line;

	// re-phase on every transition
	always_ff @(posedge usb_clk) begin
		if (usb_rst)
			cnt <= '0;
		else if (edge_seen)
			cnt <= cnt_w'(1);
		else
			cnt <= (cnt == cnt_w'(clks_per_bit - 1)) ? '0 : cnt + 1'b1;
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			rx_active <= 1'b0;
			rx_valid  <= 1'b0;
			rx_error  <= 1'b0;
			sync_sr   <= '1;
			bit_cnt   <= '0;
			ones      <= '0;
			last_lvl  <= 1'b1;
		end else begin
			rx_valid <= 1'b0;
			rx_error <= 1'b0;
			if (sample) begin
				if (!rx_active) begin
					// hunt for SYNC, single-ended states restart the search
					sync_sr <= (is_se0 || is_se1) ? 8'hff : sync_next;
					if (!is_se0 && !is_se1 && sync_next == sync_levels) begin
						rx_active <= 1'b1;
						last_lvl  <= dp;
						ones      <= 3'd1; // trailing KK of SYNC counts toward stuffing
						bit_cnt   <= '0;
					end
				end else if (is_se0) begin
					rx_active <= 1'b0; // EOP
					sync_sr   <= '1;
				end else if (is_se1) begin
					rx_error <= 1'b1;
				end else begin
					last_lvl <= dp;
					if (ones == 3'd6) begin
						ones     <= '0;
						rx_error <= bit_in; // a one here means a missing stuff bit
					end else begin
						ones    <= bit_in ? ones + 3'd1 : 3'd0;
						shift   <= {bit_in, shift[7:1]}; // lsb first
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) begin
							rx_valid <= 1'b1;
							rx_data  <= {bit_in, shift[7:1]};
						end
					end
				end
			end
		end
	end

endmodule

// ==== logic/usb_port_mux.sv ====
// port block for full speed only that needs clks_per_bit of 2 or more to mask its own echo
`timescale 1ns/10ps

module usb_port_mux #(
	parameter int clks_per_bit  = 4,
	parameter int discon_cycles = 64
) (
	input  logic                     usb_clk,
	input  logic                     usb_rst,

	output logic                     usba_spd,
	output logic                     usba_oe_n,
	input  logic                     usba_rcv,
	inout  wire                      usba_vp,
	inout  wire                      usba_vm,

	output logic                     usbb_spd,
	output logic                     usbb_oe_n,
	input  logic                     usbb_rcv,
	inout  wire                      usbb_vp,
	inout  wire                      usbb_vm,

	input  logic                     port_sel_rx,
	input  logic [1:0]               port_sel_tx,
	input  logic                     gen_reset,
	input  logic                     drive_dp,
	input  logic                     drive_dm,
	input  logic                     drive_oe,

	output usb_sie_pkg::line_state_t line_state_a,
	output usb_sie_pkg::line_state_t line_state_b,
	output logic                     discon_a,
	output logic                     discon_b,
	output usb_sie_pkg::line_state_t rx_line
);

	localparam int hold_w   = $clog2(clks_per_bit + 1);
	localparam int discon_w = $clog2(discon_cycles + 1);

	logic [1:0] port_oe; // port drives its pins
	logic [1:0] own;     // driving, or released less than a bit time ago
	logic [1:0] discon;
	logic [1:0] pin_vp, pin_vm, pin_rcv;
	logic       out_dp, out_dm;
	usb_sie_pkg::line_state_t line [2];

	assign port_oe = port_sel_tx & {2{drive_oe | gen_reset}};
	assign out_dp  = drive_dp & ~gen_reset; // bus reset is a forced SE0
	assign out_dm  = drive_dm & ~gen_reset;

	assign usba_spd  = 1'b1;
	assign usbb_spd  = 1'b1;
	assign usba_oe_n = ~port_oe[0];
	assign usbb_oe_n = ~port_oe[1];
	assign usba_vp   = port_oe[0] ? out_dp : 1'bz;
	assign usba_vm   = port_oe[0] ? out_dm : 1'bz;
	assign usbb_vp   = port_oe[1] ? out_dp : 1'bz;
	assign usbb_vm   = port_oe[1] ? out_dm : 1'bz;

	assign pin_vp  = {usbb_vp, usba_vp};
	assign pin_vm  = {usbb_vm, usba_vm};
	assign pin_rcv = {usbb_rcv, usba_rcv};

	for (genvar p = 0; p < 2; p++) begin : g_port
		logic [2:0]          meta, synced; // {rcv, vp, vm}
		logic [hold_w-1:0]   hold;
		logic [discon_w-1:0] se0_cnt;

		always_ff @(posedge usb_clk) begin
			meta   <= {pin_rcv[p], pin_vp[p], pin_vm[p]};
			synced <= meta;
		end

		// single-ended receivers give SE0/SE1, the differential one gives J/K
		assign line[p] = (synced[1] == synced[0]) ?
			usb_sie_pkg::line_state_t'(synced[1:0]) :
			usb_sie_pkg::line_state_t'({synced[2], ~synced[2]});
		assign own[p]    = port_oe[p] || (hold != '0);
		assign discon[p] = (se0_cnt == discon_w'(discon_cycles));

		always_ff @(posedge usb_clk) begin
			if (usb_rst) begin
				hold    <= '0;
				se0_cnt <= '0;
			end else begin
				if (port_oe[p])
					hold <= hold_w'(clks_per_bit); // covers the synchronizer delay
				else if (hold != '0)
					hold <= hold - 1'b1;
				if (own[p] || line[p] != usb_sie_pkg::se0)
					se0_cnt <= '0;
				else if (!discon[p])
					se0_cnt <= se0_cnt + 1'b1; // saturates at discon_cycles
			end
		end
	end

	assign line_state_a = line[0];
	assign line_state_b = line[1];
	assign discon_a     = discon[0];
	assign discon_b     = discon[1];
	assign rx_line      = port_sel_rx ? (own[1] ? usb_sie_pkg::j_state : line[1]) :
		(own[0] ? usb_sie_pkg::j_state : line[0]);

endmodule

// ==== logic/usb_sie_top.sv ====
// full-speed SIE for two ports where software handles CRC, PIDs and handshakes
`timescale 1ns/10ps

module usb_sie_top #(
	parameter int clks_per_bit  = 4,  // 48 MHz usb_clk
	parameter int discon_cycles = 64
) (
	input  logic               usb_clk,
	input  logic               usb_rst,

	input  logic               io_re,
	input  logic               io_we,
	input  usb_sie_pkg::addr_t io_a,
	input  usb_sie_pkg::byte_t io_di,
	output usb_sie_pkg::byte_t io_do,

	output logic               usba_spd,
	output logic               usba_oe_n,
	input  logic               usba_rcv,
	inout  wire                usba_vp,
	inout  wire                usba_vm,

	output logic               usbb_spd,
	output logic               usbb_oe_n,
	input  logic               usbb_rcv,
	inout  wire                usbb_vp,
	inout  wire                usbb_vm
);

	usb_sie_pkg::line_state_t line_state_a, line_state_b, rx_line;
	usb_sie_pkg::byte_t       tx_data, rx_data;
	logic                     discon_a, discon_b;
	logic                     port_sel_rx;
	logic [1:0]               port_sel_tx;
	logic                     tx_valid, tx_ready, gen_reset;
	logic                     rx_valid, rx_active, rx_error;
	logic                     drive_dp, drive_dm, drive_oe;

	usb_sie_regs regs (.*);

	usb_tx_serializer #(.clks_per_bit(clks_per_bit)) tx (.*);

	usb_rx_deserializer #(.clks_per_bit(clks_per_bit)) rx (.*);

	usb_port_mux #(
		.clks_per_bit (clks_per_bit),
		.discon_cycles(discon_cycles)
	) ports (.*);

endmodule

// ==== test/usb_clk_gen.sv ====
// free-running clock with a synchronous reset that is released on a falling edge
`timescale 1ns/10ps

module usb_clk_gen #(
	parameter int period     = 4,
	parameter int rst_cycles = 10
) (
	output logic usb_clk,
	output logic usb_rst
);

	initial begin
		usb_clk = 1'b0;
		forever #(period / 2) usb_clk = ~usb_clk;
	end

	initial begin
		usb_rst = 1'b1;
		repeat (rst_cycles) @(posedge usb_clk);
		@(negedge usb_clk);
		usb_rst = 1'b0;
	end

endmodule

// ==== test/tb_usb_sie.sv ====
// both ports share one d+/d- pair so port a sends what port b hears and timing assumes clks_per_bit 4
`timescale 1ns/10ps

module tb_usb_sie;

	localparam int clk_period     = 4;
	localparam int clks_per_bit   = 4;
	localparam int discon_cycles  = 64;
	localparam int budget_reset   = 300; // cycles allowed per test
	localparam int budget_control = 200;
	localparam int budget_single  = 500;
	localparam int budget_multi   = 1200;
	localparam int budget_error   = 800;
	localparam int total_cycles   = budget_reset + budget_control + budget_single +
		budget_multi + budget_error;
	localparam logic [7:0] sync_dp = 8'b0101_0100; // d+ levels of KJKJKJKK with the first bit on the left

	logic               usb_clk;
	logic               usb_rst;
	logic               io_re;
	logic               io_we;
	usb_sie_pkg::addr_t io_a;
	usb_sie_pkg::byte_t io_di;
	usb_sie_pkg::byte_t io_do;
	logic               usba_spd, usba_oe_n;
	logic               usbb_spd, usbb_oe_n;
	wire                dp;        // shared d+ of both ports
	wire                dm;
	logic               attached;  // device pull-up on d+
	logic               inj_en;
	logic               inj_dp;
	logic               inj_dm;
	int                 errors;
	int                 checks;
	logic [31:0]        lcg_state;
	usb_sie_pkg::byte_t pkt [16];  // bytes of the packet in flight

	// weak pulls of the device model lose to the DUT and to injection
	assign (weak0, weak1) dp = attached;
	assign (weak0, weak1) dm = 1'b0;
	assign dp = inj_en ? inj_dp : 1'bz;
	assign dm = inj_en ? inj_dm : 1'bz;

	usb_clk_gen #(.period(clk_period), .rst_cycles(10)) clk_gen (.usb_clk, .usb_rst);

	usb_sie_top #(
		.clks_per_bit (clks_per_bit),
		.discon_cycles(discon_cycles)
	) DUT (
		.usb_clk, .usb_rst, .io_re, .io_we, .io_a, .io_di, .io_do,
		.usba_spd, .usba_oe_n, .usba_rcv(dp), .usba_vp(dp), .usba_vm(dm),
		.usbb_spd, .usbb_oe_n, .usbb_rcv(dp), .usbb_vp(dp), .usbb_vm(dm)
	);

	function automatic usb_sie_pkg::byte_t next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16]; // upper bits are the better ones
	endfunction

	task automatic check_byte(input usb_sie_pkg::byte_t got, input usb_sie_pkg::byte_t want,
		input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERR %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, want);
		end
	endtask

	task automatic check_line(input usb_sie_pkg::line_state_t got,
		input usb_sie_pkg::line_state_t want, input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	task automatic check_bit(input logic got, input logic want, input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	task automatic bus_write(input usb_sie_pkg::addr_t a, input usb_sie_pkg::byte_t d);
		@(negedge usb_clk);
		io_a  = a;
		io_di = d;
		io_we = 1'b1;
		@(negedge usb_clk);
		io_we = 1'b0;
	endtask

	// io_do is registered so the data shows one cycle after the address
	task automatic bus_read(input usb_sie_pkg::addr_t a, output usb_sie_pkg::byte_t d);
		@(negedge usb_clk);
		io_a  = a;
		io_re = 1'b1;
		@(negedge usb_clk);
		io_re = 1'b0;
		d     = io_do;
	endtask

	task automatic read_until(input usb_sie_pkg::addr_t a, input usb_sie_pkg::byte_t want,
		input int limit, input string what);
		usb_sie_pkg::byte_t d;
		int cycles;
		cycles = 0;
		bus_read(a, d);
		while (d !== want && cycles < limit) begin
			bus_read(a, d);
			cycles += 2;
		end
		if (d !== want) begin
			errors++;
			$display("%s did not happen within %0d cycles", what, limit);
		end
	endtask

	task automatic expect_flag(input usb_sie_pkg::addr_t a, input logic want, input string what);
		usb_sie_pkg::byte_t d;
		bus_read(a, d);
		check_bit(d[0], want, what);
	endtask

	task automatic expect_line(input usb_sie_pkg::addr_t a, input usb_sie_pkg::line_state_t want,
		input string what);
		usb_sie_pkg::byte_t d;
		bus_read(a, d);
		check_line(usb_sie_pkg::line_state_t'(d[1:0]), want, what);
	endtask

	// feeds pkt[0..n-1] while collecting what comes back on the other port
	task automatic stream_packet(input int n, input int limit);
		usb_sie_pkg::byte_t d;
		int sent;
		int got;
		int cycles;
		logic ended;
		sent   = 1;
		got    = 0;
		cycles = 0;
		ended  = 1'b0;
		bus_write(usb_sie_pkg::reg_tx_data, pkt[0]);
		while (got < n && cycles < limit) begin
			if (!ended) begin
				bus_read(usb_sie_pkg::reg_tx_pending, d);
				cycles += 2;
				if (d[0] == 1'b0) begin
					if (sent < n) begin
						bus_write(usb_sie_pkg::reg_tx_data, pkt[sent]);
						sent++;
					end else begin
						bus_write(usb_sie_pkg::reg_tx_valid, 8'h00); // EOP after the last byte
						ended = 1'b1;
					end
					cycles += 2;
				end
			end
			bus_read(usb_sie_pkg::reg_rx_pending, d);
			cycles += 2;
			if (d[0]) begin
				bus_read(usb_sie_pkg::reg_rx_data, d);
				cycles += 2;
				check_byte(d, pkt[got], $sformatf("received byte %0d", got));
				got++;
			end
		end
		if (got < n) begin
			errors++;
			$display("only %0d of %0d bytes came back within %0d cycles", got, n, limit);
		end
	endtask

	// holds one line level for a number of bit times
	task automatic inject(input logic vp, input logic vm, input int bits);
		inj_en = 1'b1;
		inj_dp = vp;
		inj_dm = vm;
		repeat (bits * clks_per_bit) @(negedge usb_clk);
	endtask

	task automatic reset_values();
		usb_sie_pkg::byte_t d;
		check_byte(io_do, 8'h00, "io_do after reset");
		check_bit(usba_oe_n, 1'b1, "usba_oe_n after reset");
		check_bit(usbb_oe_n, 1'b1, "usbb_oe_n after reset");
		check_bit(usba_spd, 1'b1, "usba_spd full speed");
		check_bit(usbb_spd, 1'b1, "usbb_spd full speed");
		for (int a = 0; a < 16; a++) begin
			bus_read(usb_sie_pkg::addr_t'(a), d);
			check_byte(d, 8'h00, $sformatf("register 0x%02h after reset", a));
		end
		bus_read(6'h3f, d);
		check_byte(d, 8'h00, "unused register 0x3f");
		repeat (discon_cycles) @(negedge usb_clk); // pull-downs hold SE0 meanwhile
		expect_flag(usb_sie_pkg::reg_discon_a, 1'b1, "discon_a with no device");
		expect_flag(usb_sie_pkg::reg_discon_b, 1'b1, "discon_b with no device");
		attached = 1'b1;
		repeat (4) @(negedge usb_clk);
		expect_line(usb_sie_pkg::reg_line_state_a, usb_sie_pkg::j_state, "line_state_a attached");
		expect_line(usb_sie_pkg::reg_line_state_b, usb_sie_pkg::j_state, "line_state_b attached");
		expect_flag(usb_sie_pkg::reg_discon_a, 1'b0, "discon_a attached");
		expect_flag(usb_sie_pkg::reg_discon_b, 1'b0, "discon_b attached");
	endtask

	task automatic control_readback();
		usb_sie_pkg::byte_t d;
		bus_write(usb_sie_pkg::reg_port_sel_rx, 8'h01);
		bus_read(usb_sie_pkg::reg_port_sel_rx, d);
		check_byte(d, 8'h01, "port_sel_rx");
		bus_write(usb_sie_pkg::reg_port_sel_tx, 8'h03);
		bus_read(usb_sie_pkg::reg_port_sel_tx, d);
		check_byte(d, 8'h03, "port_sel_tx both ports");
		bus_write(usb_sie_pkg::reg_port_sel_tx, 8'h01);
		bus_read(usb_sie_pkg::reg_port_sel_tx, d);
		check_byte(d, 8'h01, "port_sel_tx port a");
		bus_write(usb_sie_pkg::reg_gen_reset, 8'h01);
		bus_read(usb_sie_pkg::reg_gen_reset, d);
		check_byte(d, 8'h01, "gen_reset set");
		check_bit(usba_oe_n, 1'b0, "usba_oe_n during bus reset");
		check_bit(usbb_oe_n, 1'b1, "usbb_oe_n during bus reset");
		repeat (4) @(negedge usb_clk);
		expect_line(usb_sie_pkg::reg_line_state_b, usb_sie_pkg::se0, "line_state_b in bus reset");
		bus_write(usb_sie_pkg::reg_gen_reset, 8'h00);
		bus_read(usb_sie_pkg::reg_gen_reset, d);
		check_byte(d, 8'h00, "gen_reset cleared");
		repeat (4) @(negedge usb_clk);
		expect_line(usb_sie_pkg::reg_line_state_b, usb_sie_pkg::j_state, "line_state_b after reset");
	endtask

	task automatic single_byte_loopback();
		usb_sie_pkg::byte_t d;
		bus_write(usb_sie_pkg::reg_tx_data, 8'hc3);
		read_until(usb_sie_pkg::reg_tx_pending, 8'h00, 100, "tx_pending clearing");
		bus_write(usb_sie_pkg::reg_tx_valid, 8'h00);
		read_until(usb_sie_pkg::reg_rx_pending, 8'h01, 200, "rx_pending rising");
		bus_read(usb_sie_pkg::reg_rx_data, d);
		check_byte(d, 8'hc3, "received single byte");
		expect_flag(usb_sie_pkg::reg_rx_pending, 1'b0, "rx_pending after reading rx_data");
		read_until(usb_sie_pkg::reg_rx_active, 8'h00, 100, "rx_active falling after EOP");
		repeat (2 * clks_per_bit) @(negedge usb_clk); // let the EOP J finish
	endtask

	task automatic multi_byte_loopback();
		pkt[0] = 8'hff; // six ones force a stuff bit
		pkt[1] = 8'h7e;
		for (int i = 2; i < 10; i++)
			pkt[i] = next_random();
		stream_packet(10, 1000);
		read_until(usb_sie_pkg::reg_rx_active, 8'h00, 100, "rx_active falling after EOP");
		expect_flag(usb_sie_pkg::reg_rx_error, 1'b0, "rx_error after stuffed packet");
		repeat (2 * clks_per_bit) @(negedge usb_clk);
	endtask

	task automatic stuff_error_recovery();
		@(negedge usb_clk);
		for (int i = 7; i >= 0; i--)
			inject(sync_dp[i], ~sync_dp[i], 1);
		inject(1'b1, 1'b0, 8); // the first J is a zero and seven unstuffed ones follow
		inject(1'b0, 1'b0, 2); // EOP
		inject(1'b1, 1'b0, 1);
		inj_en = 1'b0;
		read_until(usb_sie_pkg::reg_rx_active, 8'h00, 50, "rx_active falling after bad packet");
		expect_flag(usb_sie_pkg::reg_rx_error, 1'b1, "rx_error after missing stuff bit");
		pkt[0] = next_random();
		stream_packet(1, 300);
		read_until(usb_sie_pkg::reg_rx_active, 8'h00, 100, "rx_active falling after EOP");
		expect_flag(usb_sie_pkg::reg_rx_error, 1'b0, "rx_error after clean packet");
	endtask

	initial begin
		io_re     = 1'b0;
		io_we     = 1'b0;
		io_a      = '0;
		io_di     = '0;
		attached  = 1'b0;
		inj_en    = 1'b0;
		inj_dp    = 1'b1;
		inj_dm    = 1'b0;
		errors    = 0;
		checks    = 0;
		lcg_state = 32'd28261;
		while (usb_rst !== 1'b0)
			@(posedge usb_clk);
		@(negedge usb_clk);
		reset_values();
		control_readback();
		single_byte_loopback();
		multi_byte_loopback();
		stuff_error_recovery();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// watchdog
	initial begin
		#(total_cycles * clk_period);
		$display("timeout, the tests did not finish within %0d cycles", total_cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== files.f ====
logic/usb_sie_pkg.sv
logic/usb_sie_regs.sv
logic/usb_tx_serializer.sv
logic/usb_rx_deserializer.sv
logic/usb_port_mux.sv
logic/usb_sie_top.sv
test/usb_clk_gen.sv
test/tb_usb_sie.sv

// ==== Bender.yml ====
package:
  name: usb_sie

sources:
  - logic/usb_sie_pkg.sv
  - logic/usb_sie_regs.sv
  - logic/usb_tx_serializer.sv
  - logic/usb_rx_deserializer.sv
  - logic/usb_port_mux.sv
  - logic/usb_sie_top.sv
  - target: test
    files:
      - test/usb_clk_gen.sv
      - test/tb_usb_sie.sv
